// File: verilog/emesh_pkg.sv
package emesh_pkg;

   // Field widths of the mesh packet
   localparam int PW  = 104;                     // Full packet
   localparam int AW  = 32;                      // Address field
   localparam int DW  = 32;                      // Data field
   localparam int IDW = 12;                      // Chip ID inside an address

   typedef logic [PW-1:0]  packet_t;             // Mesh packet
   typedef logic [AW-1:0]  addr_t;               // Byte address
   typedef logic [DW-1:0]  data_t;               // Data word
   typedef logic [IDW-1:0] chipid_t;             // Chip ID, top bits of an address

   // Packet layout, bit 0 is unused here
   localparam int WRITE_BIT     = 1;             // 1 for write, 0 for read
   localparam int DATAMODE_LSB  = 2;             // Access size
   localparam int DATAMODE_MSB  = 3;
   localparam int CTRLMODE_LSB  = 4;             // Control mode
   localparam int CTRLMODE_MSB  = 7;
   localparam int DSTADDR_LSB   = 8;             // Destination address, bits 8 to 39
   localparam int DATA_LSB      = 40;            // Write data or read-response data
   localparam int SRCADDR_LSB   = 72;            // Source address, return path for reads

   // Chip ID position within an address
   localparam int CHIPID_LSB    = AW - IDW;

   // External memory geometry
   localparam int MEM_AW        = 8;             // Word index width
   localparam int MEM_DEPTH     = 1 << MEM_AW;   // 256 words
   localparam int WORD_LSB      = 2;             // Word index starts above the byte offset

   typedef logic [MEM_AW-1:0] mem_idx_t;         // Word index into memory

   // Quick reference of the layout, MSB on the left
   //   [103:72] srcaddr
   //   [71:40]  data
   //   [39:8]   dstaddr
   //   [7:4]    ctrlmode
   //   [3:2]    datamode
   //   [1]      write
   //   [0]      unused
   // A read response travels as a write back to the requester
   // Its dstaddr is the srcaddr of the read that caused it

endpackage

// File: verilog/elink_pkg.sv
package elink_pkg;

   // Lane geometry
   localparam int LW        = 8;                          // Byte lane width
   localparam int PKT_BYTES = emesh_pkg::PW / LW;         // 13 bytes per packet

   typedef logic [LW-1:0] lane_t;                         // One lane byte
   typedef logic [3:0]    byte_cnt_t;                     // Counts up to PKT_BYTES

   // Chip IDs of the two endpoints
   localparam emesh_pkg::chipid_t LOCAL_ID  = 12'h810;    // Requester side
   localparam emesh_pkg::chipid_t REMOTE_ID = 12'h820;    // Memory side

   // Transmitter FSM
   typedef enum logic {
      TX_IDLE,                                            // Waiting for a packet
      TX_SEND                                             // Bytes going out on the lane
   } tx_state_t;

   // Frame is high for exactly PKT_BYTES cycles per packet
   // Least significant byte goes first
   // At least one idle cycle separates two frames

endpackage

// File: verilog/link_tx.sv
`timescale 1ns/100ps

module link_tx (
   input  logic               clkin,        // Link clock
   input  logic               reset,        // Async reset, active high
   input  logic               in_access,    // Packet strobe
   input  emesh_pkg::packet_t in_packet,    // Packet to serialize
   output logic               busy,         // Transfer in flight
   output elink_pkg::lane_t   lane_data,    // Byte lane
   output logic               lane_frame    // Marks valid bytes
);
   import emesh_pkg::*;
   import elink_pkg::*;

   tx_state_t state;                        // Transmit FSM
   byte_cnt_t byte_cnt;                     // Bytes already on the lane
   packet_t   shift_reg;                    // Outgoing packet, low byte first
   logic      start;                        // Packet taken at this edge
   logic      last_byte;                    // Final byte of the packet

   // Only an idle transmitter takes a packet
   assign start     = in_access && (state == TX_IDLE);
   assign last_byte = (byte_cnt == byte_cnt_t'(PKT_BYTES - 1));

   always_ff @(posedge clkin or posedge reset) begin
      if (reset) begin
         state    <= TX_IDLE;
         byte_cnt <= '0;
      end else begin
         case (state)
            TX_IDLE: begin
               byte_cnt <= '0;              // Fresh count per packet
               if (start)
                  state <= TX_SEND;         // First byte next cycle
            end
            TX_SEND: begin
               byte_cnt <= byte_cnt + 1'b1;
               if (last_byte)
                  state <= TX_IDLE;         // Back to idle after 13 bytes
            end
            default: begin
               state <= TX_IDLE;
            end
         endcase
      end
   end

   // Payload shifter
   always_ff @(posedge clkin) begin
      if (start)
         shift_reg <= in_packet;            // Capture on acceptance
      else if (state == TX_SEND)
         shift_reg <= shift_reg >> LW;      // Next byte down to the lane
   end

   // Busy and frame cover the same 13 cycles
   assign busy       = (state == TX_SEND);
   assign lane_frame = (state == TX_SEND);
   assign lane_data  = shift_reg[LW-1:0];   // Low byte drives the lane

endmodule

// File: verilog/link_rx.sv
`timescale 1ns/100ps

module link_rx (
   input  logic               clkin,        // Link clock
   input  logic               reset,        // Async reset, active high
   input  elink_pkg::lane_t   lane_data,    // Byte lane
   input  logic               lane_frame,   // Marks valid bytes
   output logic               out_access,   // One-cycle packet strobe
   output emesh_pkg::packet_t out_packet    // Assembled packet
);
   import emesh_pkg::*;
   import elink_pkg::*;

   byte_cnt_t byte_cnt;                     // Bytes seen in this frame
   packet_t   shift_reg;                    // Packet under assembly

   // Byte counter, cleared whenever frame is low
   always_ff @(posedge clkin or posedge reset) begin
      if (reset)
         byte_cnt <= '0;
      else if (lane_frame)
         byte_cnt <= byte_cnt + 1'b1;       // One byte per framed cycle
      else
         byte_cnt <= '0;
   end

   // Bytes enter at the top, so the first byte ends up lowest
   always_ff @(posedge clkin) begin
      if (lane_frame)
         shift_reg <= {lane_data, shift_reg[PW-1:LW]};
   end

   // Frame has fallen with a full packet collected
   assign out_access = !lane_frame && (byte_cnt == byte_cnt_t'(PKT_BYTES));
   assign out_packet = shift_reg;           // Stable until the next frame

endmodule

// File: verilog/emem.sv
`timescale 1ns/100ps

module emem (
   input  logic               clkin,        // Memory clock
   input  logic               reset,        // Async reset, active high
   input  logic               in_access,    // Incoming mesh access
   input  emesh_pkg::packet_t in_packet,    // Write or read packet
   output logic               rr_access,    // Read-response strobe
   output emesh_pkg::packet_t rr_packet     // Read-response packet
);
   import emesh_pkg::*;
   import elink_pkg::*;

   data_t    mem [MEM_DEPTH];               // Word storage
   addr_t    dstaddr;                       // Target of the access
   addr_t    srcaddr;                       // Return address for reads
   chipid_t  dst_id;                        // Chip ID from dstaddr
   mem_idx_t word_idx;                      // Memory word index
   logic     is_write;                      // Write bit of the packet
   logic     hit;                           // Access reaches the memory
   packet_t  resp;                          // Response assembled from the read

   // Field decode
   assign dstaddr  = in_packet[DSTADDR_LSB +: AW];
   assign srcaddr  = in_packet[SRCADDR_LSB +: AW];
   assign dst_id   = dstaddr[CHIPID_LSB +: IDW];
   assign word_idx = dstaddr[WORD_LSB +: MEM_AW];
   assign is_write = in_packet[WRITE_BIT];

   // Remote register space is not modelled, those accesses vanish
   assign hit = in_access && (dst_id != REMOTE_ID);

   // Response goes back as a write to the requester
   always_comb begin
      resp                              = '0;
      resp[WRITE_BIT]                   = 1'b1;
      resp[DATAMODE_MSB:DATAMODE_LSB]   = in_packet[DATAMODE_MSB:DATAMODE_LSB];
      resp[CTRLMODE_MSB:CTRLMODE_LSB]   = in_packet[CTRLMODE_MSB:CTRLMODE_LSB];
      resp[DSTADDR_LSB +: AW]           = srcaddr;             // Swap addresses
      resp[DATA_LSB +: DW]              = mem[word_idx];       // Stored word
      resp[SRCADDR_LSB +: AW]           = dstaddr;
   end

   // Write port
   always_ff @(posedge clkin) begin
      if (hit && is_write)
         mem[word_idx] <= in_packet[DATA_LSB +: DW];
   end

   // Response strobe, one cycle after the read arrives
   always_ff @(posedge clkin or posedge reset) begin
      if (reset)
         rr_access <= 1'b0;
      else
         rr_access <= hit && !is_write;
   end

   // Response payload
   always_ff @(posedge clkin) begin
      if (hit && !is_write)
         rr_packet <= resp;
   end

endmodule

// File: verilog/elink_loop.sv
`timescale 1ns/100ps

module elink_loop (
   input  logic               clkin,        // Single link clock
   input  logic               reset,        // Async reset, active high
   input  logic               ext_access,   // Held until its wait is low
   input  emesh_pkg::packet_t ext_packet,   // Request from outside
   output logic               dut_rd_wait,  // Read push-back
   output logic               dut_wr_wait,  // Write push-back
   output logic               dut_access,   // Read-response strobe
   output emesh_pkg::packet_t dut_packet    // Read-response packet
);
   import emesh_pkg::*;
   import elink_pkg::*;

   logic    local_busy;                     // Local transmitter occupied
   logic    local_access;                   // Request that passed its wait
   lane_t   lane_a_data;                    // Local to remote lane
   logic    lane_a_frame;
   logic    rx_access;                      // Request at the remote end
   packet_t rx_packet;
   logic    rr_access;                      // Response from memory
   packet_t rr_packet;
   lane_t   lane_b_data;                    // Remote to local lane
   logic    lane_b_frame;

   // Both kinds share one transmitter, so both waits follow it
   assign dut_rd_wait = local_busy;
   assign dut_wr_wait = local_busy;

   // Request counts only when the wait for its kind is low
   assign local_access = ext_access &&
                         (ext_packet[WRITE_BIT] ? !dut_wr_wait : !dut_rd_wait);

   link_tx tx_local (
      .clkin      (clkin),
      .reset      (reset),
      .in_access  (local_access),
      .in_packet  (ext_packet),
      .busy       (local_busy),
      .lane_data  (lane_a_data),
      .lane_frame (lane_a_frame)
   );

   link_rx rx_remote (
      .clkin      (clkin),
      .reset      (reset),
      .lane_data  (lane_a_data),
      .lane_frame (lane_a_frame),
      .out_access (rx_access),
      .out_packet (rx_packet)
   );

   emem remote_mem (
      .clkin      (clkin),
      .reset      (reset),
      .in_access  (rx_access),
      .in_packet  (rx_packet),
      .rr_access  (rr_access),
      .rr_packet  (rr_packet)
   );

   // Responses never overlap, one read takes as long to arrive as to answer
   link_tx tx_remote (
      .clkin      (clkin),
      .reset      (reset),
      .in_access  (rr_access),
      .in_packet  (rr_packet),
      .busy       (),                       // No source to hold back
      .lane_data  (lane_b_data),
      .lane_frame (lane_b_frame)
   );

   link_rx rx_local (
      .clkin      (clkin),
      .reset      (reset),
      .lane_data  (lane_b_data),
      .lane_frame (lane_b_frame),
      .out_access (dut_access),
      .out_packet (dut_packet)
   );

endmodule

// File: test/elink_loop_assert.sv
`timescale 1ns/100ps

module elink_loop_assert (
   input logic               clkin,         // Link clock
   input logic               reset,         // Async reset, active high
   input logic               ext_access,    // Request from outside
   input emesh_pkg::packet_t ext_packet,    // Request packet
   input logic               dut_rd_wait,   // Read push-back
   input logic               dut_wr_wait,   // Write push-back
   input logic               dut_access     // Response strobe
);
   import emesh_pkg::*;
   import elink_pkg::*;

   logic kind_wait;                         // Wait that applies to the pending packet
   logic accept;                            // Packet taken at this edge
   int   failures = 0;                      // Failed assertions so far

   assign kind_wait = ext_packet[WRITE_BIT] ? dut_wr_wait : dut_rd_wait;
   assign accept    = ext_access && !kind_wait;

   // One packet keeps the transmitter busy for exactly PKT_BYTES cycles
   wait_after_accept: assert property (
      @(posedge clkin) disable iff (reset)
      accept |=> (dut_wr_wait && dut_rd_wait) [*PKT_BYTES] ##1 !(dut_wr_wait || dut_rd_wait)
   ) else begin
      $error("wait did not stay high for one packet after acceptance");
      failures++;
   end

   // Response strobe is always driven once out of reset
   access_known: assert property (
      @(posedge clkin) disable iff (reset)
      !$isunknown(dut_access)
   ) else begin
      $error("dut_access is unknown after reset");
      failures++;
   end

   // Quiet outputs in reset and on the first edge after it
   idle_after_reset: assert property (
      @(posedge clkin)
      (reset || $fell(reset)) |-> !(dut_access || dut_rd_wait || dut_wr_wait)
   ) else begin
      $error("outputs not low during or right after reset");
      failures++;
   end

endmodule

bind elink_loop elink_loop_assert u_assert (
   .clkin       (clkin),
   .reset       (reset),
   .ext_access  (ext_access),
   .ext_packet  (ext_packet),
   .dut_rd_wait (dut_rd_wait),
   .dut_wr_wait (dut_wr_wait),
   .dut_access  (dut_access)
);

// File: test/tb_elink_loop.sv
`timescale 1ns/100ps

module tb_elink_loop;
   import emesh_pkg::*;
   import elink_pkg::*;

   localparam chipid_t MEM_ID   = 12'h808;          // Chip ID the memory answers
   localparam int      NUM_PKTS = 2 + 20 + 5 + 4;   // Packets over all tests
   localparam int      QUIET    = 40;               // Longer than one round trip

   logic    clkin;
   logic    reset;
   logic    ext_access;
   packet_t ext_packet;
   logic    dut_rd_wait;
   logic    dut_wr_wait;
   logic    dut_access;
   packet_t dut_packet;

   data_t   shadow [MEM_DEPTH];                     // Reference memory
   logic    shadow_valid [MEM_DEPTH];               // Word written at least once
   packet_t exp_q [$];                              // Responses still owed in arrival order
   int      errors;
   int      checks;
   int      tests;
   int      test_errors;                            // Error count at test start
   int      responses;                              // Strobes seen on dut_access

   elink_loop dut (
      .clkin       (clkin),
      .reset       (reset),
      .ext_access  (ext_access),
      .ext_packet  (ext_packet),
      .dut_rd_wait (dut_rd_wait),
      .dut_wr_wait (dut_wr_wait),
      .dut_access  (dut_access),
      .dut_packet  (dut_packet)
   );

   always #4 clkin = ~clkin;                        // 8 ns period

   // Mesh packet fields packed from srcaddr down to the unused bit
   function automatic packet_t build_packet(input logic wr, input addr_t dst, input data_t data,
                                            input addr_t src, input logic [5:0] modes);
      return {src, data, dst, modes, wr, 1'b0};
   endfunction

   // Response owed for a read, sent back as a write with swapped addresses
   function automatic packet_t expect_response(input packet_t rd, input data_t data);
      return {rd[39:8], data, rd[103:72], rd[7:2], 1'b1, 1'b0};
   endfunction

   task automatic check_low(input string name, input logic val);
      checks++;
      assert (val === 1'b0) else begin
         $display("error: %s = %h, expected 0", name, val);
         errors++;
      end
   endtask

   // Hold the request until the edge where its wait is low
   task automatic present(input packet_t p);
      ext_access <= 1'b1;
      ext_packet <= p;
      @(posedge clkin);
      while (p[WRITE_BIT] ? dut_wr_wait : dut_rd_wait)
         @(posedge clkin);
   endtask

   task automatic send_write(input mem_idx_t idx, input data_t data, input chipid_t id);
      packet_t p;
      p = build_packet(1'b1, {id, 10'h0, idx, 2'b00}, data, {LOCAL_ID, 20'($urandom())},
                       6'($urandom()));
      if (id != REMOTE_ID) begin                    // Remote ID never reaches memory
         shadow[idx]       = data;
         shadow_valid[idx] = 1'b1;
      end
      present(p);
   endtask

   task automatic send_read(input mem_idx_t idx, input chipid_t id);
      packet_t p;
      p = build_packet(1'b0, {id, 10'h0, idx, 2'b00}, 32'h0, {LOCAL_ID, 20'($urandom())},
                       6'($urandom()));
      if (id != REMOTE_ID)
         exp_q.push_back(expect_response(p, shadow[idx]));
      present(p);
   endtask

   task automatic drain;
      ext_access <= 1'b0;
      while (exp_q.size() != 0)
         @(posedge clkin);
      repeat (QUIET) @(posedge clkin);              // Catch stray responses
   endtask

   task automatic end_test(input string name);
      tests++;
      $display("test %-12s %0d errors", name, errors - test_errors);
      test_errors = errors;
   endtask

   // Every response against the head of the queue
   always @(posedge clkin) begin
      if (!reset && dut_access) begin
         responses++;
         checks++;
         assert (exp_q.size() != 0) else begin
            $display("response on dut_access arrived with no read pending");
            errors++;
         end
         if (exp_q.size() != 0) begin
            assert (dut_packet === exp_q[0]) else begin
               $display("error: dut_packet = %h, expected %h", dut_packet, exp_q[0]);
               errors++;
            end
            void'(exp_q.pop_front());
         end
      end
   end

   initial begin
      repeat (NUM_PKTS * 50 + 300) @(posedge clkin);
      $display("watchdog expired before the tests finished");
      $display("Something failed");
      $finish;
   end

   initial begin
      mem_idx_t idx;
      int       start_resp;
      void'($urandom(54));
      clkin       = 1'b0;
      reset       = 1'b1;
      ext_access  = 1'b0;
      ext_packet  = '0;
      errors      = 0;
      checks      = 0;
      tests       = 0;
      test_errors = 0;
      responses   = 0;
      foreach (shadow_valid[i])
         shadow_valid[i] = 1'b0;

      repeat (4) begin                              // Reset held 4 cycles
         @(posedge clkin);
         check_low("dut_access", dut_access);
         check_low("dut_rd_wait", dut_rd_wait);
         check_low("dut_wr_wait", dut_wr_wait);
      end
      reset <= 1'b0;
      @(posedge clkin);
      check_low("dut_access", dut_access);
      check_low("dut_rd_wait", dut_rd_wait);
      check_low("dut_wr_wait", dut_wr_wait);
      end_test("reset");

      start_resp = responses;
      send_write(8'h15, 32'hcafe_0123, MEM_ID);
      send_read(8'h15, MEM_ID);
      drain();
      checks++;
      assert (responses == start_resp + 1) else begin
         $display("error: response count = %h, expected %h", responses, start_resp + 1);
         errors++;
      end
      end_test("write_read");

      for (int i = 0; i < 20; i++) begin
         idx = mem_idx_t'($urandom_range(15, 0));
         if (!shadow_valid[idx] || $urandom_range(1, 0) == 0)
            send_write(idx, $urandom(), MEM_ID);   // Reads only from filled words
         else
            send_read(idx, MEM_ID);
         if ($urandom_range(1, 0) == 1) begin      // Random gap before some packets
            ext_access <= 1'b0;
            repeat (1 + $urandom_range(3, 0)) @(posedge clkin);
         end
      end
      drain();
      end_test("random");

      send_write(8'h15, 32'h0bad_f00d, REMOTE_ID);
      send_read(8'h15, REMOTE_ID);
      send_write(8'h03, 32'h0bad_0003, REMOTE_ID);
      send_read(8'h03, REMOTE_ID);
      send_read(8'h15, MEM_ID);                     // Earlier data must survive
      drain();
      end_test("dropped");

      send_write(8'h40, 32'h1111_4040, MEM_ID);     // Held through each wait
      send_write(8'h41, 32'h2222_4141, MEM_ID);
      send_read(8'h41, MEM_ID);
      send_read(8'h40, MEM_ID);
      drain();
      end_test("backpressure");

      $display("tests %0d, checks %0d, responses %0d, errors %0d, assertion failures %0d",
               tests, checks, responses, errors, dut.u_assert.failures);
      if (errors == 0 && dut.u_assert.failures == 0)
         $display("Everything OK");
      else
         $display("Something failed");
      $finish;
   end

endmodule

// File: tb.f
verilog/emesh_pkg.sv
verilog/elink_pkg.sv
verilog/link_tx.sv
verilog/link_rx.sv
verilog/emem.sv
verilog/elink_loop.sv
test/elink_loop_assert.sv
test/tb_elink_loop.sv

// File: Makefile
# Verilator build and run of the elink loopback testbench

VERILATOR ?= verilator
TOP       ?= tb_elink_loop
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= Everything OK

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator, run, and search $(LOG) for the pass line"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "Variables: VERILATOR TOP FILELIST OBJ_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -qx "$(PASS_MSG)" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
